//--- Makefile
# Verilator build and run for the multi-cycle RV32I core

VERILATOR ?= verilator
TOP ?= tb_cpuCore
DUT_TOP ?= cpuCore
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Done: no errors
VFLAGS ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- aluUnit.sv
// ALU: add/sub, shifts, logic, set-less-than, plus the six branch comparisons
`timescale 1ns/1ps
`default_nettype none

module aluUnit import cpuPkg::*; (
    input  wire logic [XLEN-1:0] a,
    input  wire logic [XLEN-1:0] b,
    input  wire aluOpE op,
    input  wire logic [2:0] funct3,
    output logic [XLEN-1:0] result,
    output logic branchTaken
);

    logic eq;
    logic lt;
    logic ltu;

    assign eq = (a == b);
    assign lt = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_SLL: result = a << b[4:0];
            ALU_SLT: result = {{(XLEN-1){1'b0}}, lt};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, ltu};
            ALU_XOR: result = a ^ b;
            ALU_SRL: result = a >> b[4:0];
            ALU_SRA: result = $signed(a) >>> b[4:0];
            ALU_OR: result = a | b;
            ALU_AND: result = a & b;
            default: result = a + b;
        endcase
    end

    // beq bne blt bge bltu bgeu
    always_comb begin
        case (funct3)
            3'b000: branchTaken = eq;
            3'b001: branchTaken = !eq;
            3'b100: branchTaken = lt;
            3'b101: branchTaken = !lt;
            3'b110: branchTaken = ltu;
            3'b111: branchTaken = !ltu;
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- byteLane.sv
// byte-lane unit: load lane extraction with extension, store lane merge into the memory word
`timescale 1ns/1ps
`default_nettype none

module byteLane import cpuPkg::*; (
    input  wire logic [2:0] funct3,
    input  wire logic [1:0] byteAddr,
    input  wire logic [XLEN-1:0] memWord,
    input  wire logic [XLEN-1:0] storeData,
    output logic [XLEN-1:0] loadValue,
    output logic [XLEN-1:0] storeWord
);

    logic [XLEN-1:0] shifted;

    // addressed lane moved down to bit 0
    assign shifted = memWord >> {byteAddr, 3'b000};

    // funct3[2] selects zero extension
    always_comb begin
        case (funct3[1:0])
            2'b00: loadValue = {{24{shifted[7] & ~funct3[2]}}, shifted[7:0]};
            2'b01: loadValue = {{16{shifted[15] & ~funct3[2]}}, shifted[15:0]};
            default: loadValue = memWord;
        endcase
    end

    always_comb begin
        storeWord = memWord;
        case (funct3[1:0])
            2'b00: storeWord[{byteAddr, 3'b000} +: 8] = storeData[7:0];
            2'b01: storeWord[{byteAddr[1], 4'b0000} +: 16] = storeData[15:0];
            default: storeWord = storeData;
        endcase
    end

endmodule

`default_nettype wire

//--- controlFsm.sv
// control FSM: state register, ALU function decode and per-state datapath strobes
`timescale 1ns/1ps
`default_nettype none

module controlFsm import cpuPkg::*; (
    input  wire logic clk,
    input  wire logic clr,
    input  wire instWord inst,
    input  wire logic branchTaken,
    output ctrlBus ctrl
);

    stateE state;
    stateE nextState;
    aluOpE funcOp;

    always_ff @(posedge clk or negedge clr) begin
        if (!clr) begin
            state <= S_FETCH;
        end else begin
            state <= nextState;
        end
    end

    // funct3 / funct7 bit to ALU function, sub only for register ops
    always_comb begin
        case (inst.rType.funct3)
            3'b000: funcOp = (inst.rType.opcode == OP_OP && inst.rType.funct7[5]) ?
                             ALU_SUB : ALU_ADD;
            3'b001: funcOp = ALU_SLL;
            3'b010: funcOp = ALU_SLT;
            3'b011: funcOp = ALU_SLTU;
            3'b100: funcOp = ALU_XOR;
            3'b101: funcOp = inst.rType.funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110: funcOp = ALU_OR;
            default: funcOp = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl = '0;
        ctrl.aSel = A_ZERO;
        ctrl.bSel = B_FOUR;
        ctrl.aluOp = ALU_ADD;
        ctrl.wbSel = WB_ALU;
        nextState = S_FETCH;
        case (state)
            S_FETCH: begin
                // PC + 4 back into PC while the word is latched
                ctrl.instWrite = 1'b1;
                ctrl.pcWrite = 1'b1;
                ctrl.aSel = A_PC;
                nextState = S_DECODE;
            end
            S_DECODE: begin
                // branch/jump target parked in the ALU-output register
                ctrl.regFetch = 1'b1;
                ctrl.aSel = A_OLDPC;
                ctrl.bSel = B_IMM;
                ctrl.aluOutWrite = 1'b1;
                nextState = S_EXECUTE;
            end
            S_EXECUTE: begin
                case (inst.rType.opcode)
                    OP_JAL: begin
                        ctrl.pcWrite = 1'b1;
                        ctrl.pcSel = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.wbSel = WB_PC4;
                        ctrl.retire = 1'b1;
                    end
                    OP_JALR: begin
                        ctrl.aSel = A_RS1;
                        ctrl.bSel = B_IMM;
                        ctrl.pcWrite = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.wbSel = WB_PC4;
                        ctrl.retire = 1'b1;
                    end
                    OP_BRANCH: begin
                        ctrl.aSel = A_RS1;
                        ctrl.bSel = B_RS2;
                        ctrl.pcWriteCond = branchTaken;
                        ctrl.pcSel = 1'b1;
                        ctrl.retire = 1'b1;
                    end
                    OP_LUI: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.wbSel = WB_IMM;
                        ctrl.retire = 1'b1;
                    end
                    OP_AUIPC: begin
                        ctrl.aSel = A_OLDPC;
                        ctrl.bSel = B_IMM;
                        ctrl.aluOutWrite = 1'b1;
                        nextState = S_WRITEBACK;
                    end
                    OP_OP, OP_IMM: begin
                        ctrl.aSel = A_RS1;
                        ctrl.bSel = (inst.rType.opcode == OP_OP) ? B_RS2 : B_IMM;
                        ctrl.aluOp = funcOp;
                        ctrl.aluOutWrite = 1'b1;
                        nextState = S_WRITEBACK;
                    end
                    OP_LOAD, OP_STORE: begin
                        ctrl.aSel = A_RS1;
                        ctrl.bSel = B_IMM;
                        ctrl.aluOutWrite = 1'b1;
                        nextState = (inst.rType.opcode == OP_LOAD) ? S_MEMREAD : S_MEMWRITE;
                    end
                    // anything else retires as a no-op
                    default: ctrl.retire = 1'b1;
                endcase
            end
            S_MEMREAD: begin
                ctrl.addrSelAlu = 1'b1;
                nextState = S_WRITEBACK;
            end
            S_MEMWRITE: begin
                ctrl.addrSelAlu = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.retire = 1'b1;
            end
            S_WRITEBACK: begin
                ctrl.addrSelAlu = (inst.rType.opcode == OP_LOAD);
                ctrl.wbSel = (inst.rType.opcode == OP_LOAD) ? WB_LOAD : WB_ALU;
                ctrl.regWrite = 1'b1;
                ctrl.retire = 1'b1;
            end
            default: nextState = S_FETCH;
        endcase
    end

    stateLegal: assert property (@(posedge clk) disable iff (!clr)
        state inside {S_FETCH, S_DECODE, S_EXECUTE, S_MEMREAD, S_MEMWRITE, S_WRITEBACK});

    // a store never writes a register, and only follows execute
    storeOnly: assert property (@(posedge clk) disable iff (!clr)
        ctrl.memWrite |-> !ctrl.regWrite && $past(state) == S_EXECUTE);

endmodule

`default_nettype wire

//--- cpuCore.sv
// core top: PC and holding registers, operand and writeback muxes, retire trace, submodules
`timescale 1ns/1ps
`default_nettype none

module cpuCore import cpuPkg::*; (
    input  wire logic clk,
    input  wire logic clr,
    output logic retireValid,
    output retireInfo retire
);

    ctrlBus ctrl;
    instWord instReg;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] oldPc;
    logic [XLEN-1:0] rs1Reg;
    logic [XLEN-1:0] rs2Reg;
    logic [XLEN-1:0] aluOutReg;
    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] aluA;
    logic [XLEN-1:0] aluB;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] memAddr;
    logic [XLEN-1:0] memWord;
    logic [XLEN-1:0] loadValue;
    logic [XLEN-1:0] storeWord;
    logic [XLEN-1:0] wbData;
    logic [XLEN-1:0] pcNext;
    logic [XLEN-1:0] pcPlus4;
    logic branchTaken;

    assign pcPlus4 = oldPc + XLEN'(4);
    assign memAddr = ctrl.addrSelAlu ? aluOutReg : pc;
    // bit 0 cleared for JALR targets
    assign pcNext = ctrl.pcSel ? aluOutReg : {aluResult[XLEN-1:1], 1'b0};

    always_comb begin
        case (ctrl.aSel)
            A_PC: aluA = pc;
            A_OLDPC: aluA = oldPc;
            A_RS1: aluA = rs1Reg;
            A_ZERO: aluA = '0;
        endcase
        case (ctrl.bSel)
            B_RS2: aluB = rs2Reg;
            B_FOUR: aluB = XLEN'(4);
            B_IMM: aluB = imm;
            default: aluB = '0;
        endcase
        case (ctrl.wbSel)
            WB_ALU: wbData = aluOutReg;
            WB_LOAD: wbData = loadValue;
            WB_IMM: wbData = imm;
            WB_PC4: wbData = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge clr) begin
        if (!clr) begin
            pc <= RESET_PC;
            retireValid <= 1'b0;
        end else begin
            if (ctrl.pcWrite || ctrl.pcWriteCond) begin
                pc <= pcNext;
            end
            retireValid <= ctrl.retire;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.instWrite) begin
            instReg <= memWord;
            oldPc <= pc;
        end
        if (ctrl.regFetch) begin
            rs1Reg <= rs1Data;
            rs2Reg <= rs2Data;
        end
        if (ctrl.aluOutWrite) begin
            aluOutReg <= aluResult;
        end
        // trace sampled on the same edge as the register write
        if (ctrl.retire) begin
            retire.pc <= oldPc;
            retire.rd <= ctrl.regWrite ? instReg.rType.rd : 5'd0;
            retire.data <= (ctrl.regWrite && instReg.rType.rd != 5'd0) ? wbData : '0;
        end
    end

    controlFsm u_controlFsm (
        .clk(clk),
        .clr(clr),
        .inst(instReg),
        .branchTaken(branchTaken),
        .ctrl(ctrl)
    );

    regFile u_regFile (
        .clk(clk),
        .rs1Addr(instReg.rType.rs1),
        .rs2Addr(instReg.rType.rs2),
        .rdAddr(instReg.rType.rd),
        .rdData(wbData),
        .writeEn(ctrl.regWrite),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data)
    );

    immDecode u_immDecode (
        .inst(instReg),
        .imm(imm)
    );

    aluUnit u_aluUnit (
        .a(aluA),
        .b(aluB),
        .op(ctrl.aluOp),
        .funct3(instReg.rType.funct3),
        .result(aluResult),
        .branchTaken(branchTaken)
    );

    byteLane u_byteLane (
        .funct3(instReg.rType.funct3),
        .byteAddr(aluOutReg[1:0]),
        .memWord(memWord),
        .storeData(rs2Reg),
        .loadValue(loadValue),
        .storeWord(storeWord)
    );

    unifiedMem u_unifiedMem (
        .clk(clk),
        .addr(memAddr),
        .writeEn(ctrl.memWrite),
        .writeData(storeWord),
        .readData(memWord)
    );

    // data accesses through the byte lanes stay naturally aligned
    halfAligned: assert property (@(posedge clk) disable iff (!clr)
        ctrl.addrSelAlu && instReg.rType.funct3[1:0] == 2'b01 |-> !aluOutReg[0]);
    wordAligned: assert property (@(posedge clk) disable iff (!clr)
        ctrl.addrSelAlu && instReg.rType.funct3[1:0] == 2'b10 |-> aluOutReg[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- cpuPkg.sv
// cpu package: sizes, select codes, instruction union, opcode/state/ALU enums, control and retire structs
`default_nettype none

package cpuPkg;

    localparam int XLEN = 32;
    localparam int MEM_WORDS = 1024;
    localparam int ADDR_BITS = $clog2(MEM_WORDS);
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
    localparam MEM_FILE = "program.hex";

    // operand A sources
    localparam logic [1:0] A_PC = 2'd0;
    localparam logic [1:0] A_OLDPC = 2'd1;
    localparam logic [1:0] A_RS1 = 2'd2;
    localparam logic [1:0] A_ZERO = 2'd3;

    // operand B sources
    localparam logic [1:0] B_RS2 = 2'd0;
    localparam logic [1:0] B_FOUR = 2'd1;
    localparam logic [1:0] B_IMM = 2'd2;

    // writeback sources
    localparam logic [1:0] WB_ALU = 2'd0;
    localparam logic [1:0] WB_LOAD = 2'd1;
    localparam logic [1:0] WB_IMM = 2'd2;
    localparam logic [1:0] WB_PC4 = 2'd3;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_OP     = 7'b0110011
    } opcodeE;

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEMREAD,
        S_MEMWRITE,
        S_WRITEBACK
    } stateE;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } aluOpE;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } uTypeT;

    typedef struct packed {
        logic imm20;
        logic [9:0] imm10_1;
        logic imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeT;

    // one instruction word, viewed per format
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        sTypeT sType;
        bTypeT bType;
        uTypeT uType;
        jTypeT jType;
    } instWord;

    typedef struct packed {
        logic pcWrite;
        logic pcWriteCond;
        logic addrSelAlu;
        logic memWrite;
        logic instWrite;
        logic regFetch;
        logic regWrite;
        logic aluOutWrite;
        logic [1:0] aSel;
        logic [1:0] bSel;
        aluOpE aluOp;
        logic [1:0] wbSel;
        logic pcSel;        // 1 takes the ALU-output register
        logic retire;
    } ctrlBus;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [4:0] rd;
        logic [XLEN-1:0] data;
    } retireInfo;

endpackage

`default_nettype wire

//--- filelist.f
cpuPkg.sv
regFile.sv
immDecode.sv
aluUnit.sv
byteLane.sv
unifiedMem.sv
controlFsm.sv
cpuCore.sv
tb_cpuCore.sv

//--- immDecode.sv
// immediate decoder: sign-extended I, S, B, U and J immediates from the instruction word
`timescale 1ns/1ps
`default_nettype none

module immDecode import cpuPkg::*; (
    input  wire instWord inst,
    output logic [XLEN-1:0] imm
);

    always_comb begin
        case (inst.rType.opcode)
            OP_STORE: begin
                imm = {{20{inst.sType.imm11_5[6]}}, inst.sType.imm11_5, inst.sType.imm4_0};
            end
            OP_BRANCH: begin
                imm = {{19{inst.bType.imm12}}, inst.bType.imm12, inst.bType.imm11,
                       inst.bType.imm10_5, inst.bType.imm4_1, 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                imm = {inst.uType.imm31_12, 12'b0};
            end
            OP_JAL: begin
                imm = {{11{inst.jType.imm20}}, inst.jType.imm20, inst.jType.imm19_12,
                       inst.jType.imm11, inst.jType.imm10_1, 1'b0};
            end
            // loads, OP-IMM and JALR
            default: begin
                imm = {{20{inst.iType.imm11_0[11]}}, inst.iType.imm11_0};
            end
        endcase
    end

endmodule

`default_nettype wire

//--- program.hex
// one instruction word per line from byte address 0; load/store data lives at 0x200
00500093 // 00 addi x1, x0, 5
FFD00113 // 04 addi x2, x0, -3
002081B3 // 08 add  x3, x1, x2
40208233 // 0c sub  x4, x1, x2
00309293 // 10 slli x5, x1, 3
40115313 // 14 srai x6, x2, 1
001153B3 // 18 srl  x7, x2, x1
00112433 // 1c slt  x8, x2, x1
001134B3 // 20 sltu x9, x2, x1
0F00C513 // 24 xori x10, x1, 0xf0
0050E5B3 // 28 or   x11, x1, x5
00F5F613 // 2c andi x12, x11, 0xf
00708013 // 30 addi x0, x1, 7
123456B7 // 34 lui  x13, 0x12345
00001717 // 38 auipc x14, 0x1
008007EF // 3c jal  x15, +8
06300093 // 40 addi x1, x0, 99 (skipped)
02428867 // 44 jalr x16, 36(x5)
06300093 // 48 addi x1, x0, 99 (skipped)
00208463 // 4c beq  x1, x2, +8
00209463 // 50 bne  x1, x2, +8
06300093 // 54 addi x1, x0, 99 (skipped)
00114463 // 58 blt  x2, x1, +8
06300093 // 5c addi x1, x0, 99 (skipped)
00115463 // 60 bge  x2, x1, +8
00116463 // 64 bltu x2, x1, +8
00117463 // 68 bgeu x2, x1, +8
06300093 // 6c addi x1, x0, 99 (skipped)
20000A13 // 70 addi x20, x0, 0x200
89ABDAB7 // 74 lui  x21, 0x89abd
DEFA8A93 // 78 addi x21, x21, -529
015A2023 // 7c sw   x21, 0(x20)
001A1123 // 80 sh   x1, 2(x20)
002A00A3 // 84 sb   x2, 1(x20)
000A2B03 // 88 lw   x22, 0(x20)
000A1B83 // 8c lh   x23, 0(x20)
000A5C03 // 90 lhu  x24, 0(x20)
001A0C83 // 94 lb   x25, 1(x20)
000A4D03 // 98 lbu  x26, 0(x20)
0000006F // 9c jal  x0, 0

//--- regFile.sv
// 32 x 32 register file with two async read ports, one clocked write port and x0 held at zero
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuPkg::*; (
    input  wire logic clk,
    input  wire logic [4:0] rs1Addr,
    input  wire logic [4:0] rs2Addr,
    input  wire logic [4:0] rdAddr,
    input  wire logic [XLEN-1:0] rdData,
    input  wire logic writeEn,
    output logic [XLEN-1:0] rs1Data,
    output logic [XLEN-1:0] rs2Data
);

    logic [XLEN-1:0] regs [32];

    // x0 cleared on every edge and never takes a write
    always_ff @(posedge clk) begin
        regs[0] <= '0;
        if (writeEn && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

    x0Rs1: assert property (@(posedge clk) rs1Addr == 5'd0 |-> rs1Data == '0);
    x0Rs2: assert property (@(posedge clk) rs2Addr == 5'd0 |-> rs2Data == '0);

endmodule

`default_nettype wire

//--- tb_cpuCore.sv
// testbench for cpuCore: clock, reset, expected retire table, retire checker and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_cpuCore import cpuPkg::*; ();

    localparam int RESET_CYCLES = 4;
    // longest instruction is a load
    localparam int MAX_CPI = 5;
    localparam int MARGIN = 20;

    logic clk;
    logic clr;
    logic retireValid;
    retireInfo retire;

    retireInfo expectQ[$];
    int errorCount;
    int checkedCount;
    int cycleCount;
    int timeoutLimit;

    cpuCore u_cpuCore (
        .clk(clk),
        .clr(clr),
        .retireValid(retireValid),
        .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic addExpected(input logic [XLEN-1:0] pc, input logic [4:0] rd,
                               input logic [XLEN-1:0] data);
        retireInfo entry;
        entry.pc = pc;
        entry.rd = rd;
        entry.data = data;
        expectQ.push_back(entry);
    endtask

    // worked out by hand from program.hex, in program order
    task automatic loadTable();
        // x1 = 5, x2 = -3, then register and immediate ops
        addExpected(32'h00, 5'd1, 32'h0000_0005);
        addExpected(32'h04, 5'd2, 32'hFFFF_FFFD);
        addExpected(32'h08, 5'd3, 32'h0000_0002);
        addExpected(32'h0C, 5'd4, 32'h0000_0008);
        addExpected(32'h10, 5'd5, 32'h0000_0028);
        addExpected(32'h14, 5'd6, 32'hFFFF_FFFE);
        addExpected(32'h18, 5'd7, 32'h07FF_FFFF);
        addExpected(32'h1C, 5'd8, 32'h0000_0001);
        addExpected(32'h20, 5'd9, 32'h0000_0000);
        addExpected(32'h24, 5'd10, 32'h0000_00F5);
        addExpected(32'h28, 5'd11, 32'h0000_002D);
        addExpected(32'h2C, 5'd12, 32'h0000_000D);
        // addi into x0
        addExpected(32'h30, 5'd0, 32'h0000_0000);
        // lui, auipc, jal +8, jalr to 0x4c
        addExpected(32'h34, 5'd13, 32'h1234_5000);
        addExpected(32'h38, 5'd14, 32'h0000_1038);
        addExpected(32'h3C, 5'd15, 32'h0000_0040);
        addExpected(32'h44, 5'd16, 32'h0000_0048);
        // beq no, bne yes, blt yes, bge no, bltu no, bgeu yes
        addExpected(32'h4C, 5'd0, 32'h0000_0000);
        addExpected(32'h50, 5'd0, 32'h0000_0000);
        addExpected(32'h58, 5'd0, 32'h0000_0000);
        addExpected(32'h60, 5'd0, 32'h0000_0000);
        addExpected(32'h64, 5'd0, 32'h0000_0000);
        addExpected(32'h68, 5'd0, 32'h0000_0000);
        // base address and store data
        addExpected(32'h70, 5'd20, 32'h0000_0200);
        addExpected(32'h74, 5'd21, 32'h89AB_D000);
        addExpected(32'h78, 5'd21, 32'h89AB_CDEF);
        // sw, sh upper half, sb byte 1
        addExpected(32'h7C, 5'd0, 32'h0000_0000);
        addExpected(32'h80, 5'd0, 32'h0000_0000);
        addExpected(32'h84, 5'd0, 32'h0000_0000);
        // word is now 0005fdef
        addExpected(32'h88, 5'd22, 32'h0005_FDEF);
        addExpected(32'h8C, 5'd23, 32'hFFFF_FDEF);
        addExpected(32'h90, 5'd24, 32'h0000_FDEF);
        addExpected(32'h94, 5'd25, 32'hFFFF_FFFD);
        addExpected(32'h98, 5'd26, 32'h0000_00EF);
        // self-loop
        addExpected(32'h9C, 5'd0, 32'h0000_0000);
    endtask

    task automatic checkValue(input string what, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] want);
        if (got !== want) begin
            errorCount++;
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    // one retire pulse, or give up at the cycle limit
    task automatic waitRetire(output bit gotIt);
        gotIt = 1'b0;
        while (!gotIt && cycleCount < timeoutLimit) begin
            @(negedge clk);
            cycleCount++;
            gotIt = (retireValid === 1'b1);
        end
    endtask

    task automatic compareRetire(input int idx);
        retireInfo want;
        want = expectQ[idx];
        checkValue($sformatf("retire %0d pc", idx), retire.pc, want.pc);
        checkValue($sformatf("retire %0d rd", idx), XLEN'(retire.rd), XLEN'(want.rd));
        checkValue($sformatf("retire %0d data", idx), retire.data, want.data);
        checkedCount++;
    endtask

    task automatic finishRun();
        $display("errors: %0d, retires checked: %0d of %0d, cycles: %0d",
                 errorCount, checkedCount, expectQ.size(), cycleCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    initial begin
        bit gotRetire;
        bit timedOut;
        int idx;
        clr = 1'b0;
        errorCount = 0;
        checkedCount = 0;
        cycleCount = 0;
        timedOut = 1'b0;
        idx = 0;
        loadTable();
        timeoutLimit = expectQ.size() * MAX_CPI + MARGIN;

        // no retire while clr is low
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            checkValue("retireValid during reset", XLEN'(retireValid), '0);
        end
        @(posedge clk);
        clr <= 1'b1;

        while (idx < expectQ.size() && !timedOut) begin
            waitRetire(gotRetire);
            if (!gotRetire) begin
                errorCount++;
                timedOut = 1'b1;
                $display("timed out waiting for retire %0d, expected at pc %h",
                         idx, expectQ[idx].pc);
            end else begin
                compareRetire(idx);
                idx++;
            end
        end
        finishRun();
    end

endmodule

`default_nettype wire

//--- unifiedMem.sv
// unified memory: word array with hex preload, async read and clocked write
`timescale 1ns/1ps
`default_nettype none

module unifiedMem import cpuPkg::*; (
    input  wire logic clk,
    input  wire logic [XLEN-1:0] addr,
    input  wire logic writeEn,
    input  wire logic [XLEN-1:0] writeData,
    output logic [XLEN-1:0] readData
);

    logic [XLEN-1:0] mem [MEM_WORDS];
    logic [ADDR_BITS-1:0] wordAddr;

    initial begin
        $readmemh(MEM_FILE, mem);
    end

    // byte address in, word index out
    assign wordAddr = addr[ADDR_BITS+1:2];
    assign readData = mem[wordAddr];

    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[wordAddr] <= writeData;
        end
    end

    // stores must land inside the array
    writeInRange: assert property (@(posedge clk) writeEn |-> addr < XLEN'(MEM_WORDS * 4));

endmodule

`default_nettype wire
